//--- src/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

   typedef logic [31:0] word_t;
   typedef logic [4:0]  reg_idx_t;
   typedef logic [31:0] instr_t;

   // Instruction field positions
   localparam int TYPE_MSB   = 31;
   localparam int TYPE_LSB   = 27;
   localparam int RD_MSB     = 26;
   localparam int RD_LSB     = 22;
   localparam int RS0_MSB    = 21;
   localparam int RS0_LSB    = 17;
   localparam int RS1_MSB    = 16;
   localparam int RS1_LSB    = 12;
   localparam int IMM_MSB    = 16;   // Zero-extended
   localparam int IMM_LSB    = 0;
   localparam int ALU_OP_MSB = 3;
   localparam int ALU_OP_LSB = 0;

   typedef enum logic [4:0] {
      INSTR_NOP            = 5'd0,
      INSTR_ALU_OP         = 5'd1,
      INSTR_LOAD_IMMEDIATE = 5'd2,
      INSTR_LOAD           = 5'd3,
      INSTR_STORE          = 5'd4,
      INSTR_JUMP           = 5'd5,
      INSTR_HALT           = 5'd6
   } instr_type_e;

   typedef enum logic [2:0] {
      STAGE_IDLE            = 3'd0,
      STAGE_FETCH           = 3'd1,
      STAGE_DECODE          = 3'd2,
      STAGE_EXECUTE         = 3'd3,
      STAGE_MEMORY_READ     = 3'd4,
      STAGE_REGISTER_UPDATE = 3'd5,
      STAGE_HALTED          = 3'd6
   } stage_e;

   typedef enum logic [3:0] {
      ALU_ADD = 4'd0,
      ALU_SUB = 4'd1,
      ALU_AND = 4'd2,
      ALU_OR  = 4'd3,
      ALU_XOR = 4'd4,
      ALU_SHL = 4'd5,
      ALU_SHR = 4'd6,
      ALU_SLT = 4'd7   // Signed compare
   } alu_op_e;

endpackage

`default_nettype wire

//--- src/instr_memory.sv
`timescale 1ns/1ps
`default_nettype none

module instr_memory
   import cpu_pkg::*;
#(
   parameter int IMEM_ADDR_W = 6
) (
   input  wire                   clk_i,
   input  wire                   load_we_i,
   input  wire [IMEM_ADDR_W-1:0] load_addr_i,
   input  wire instr_t           load_data_i,
   input  wire                   fetch_en_i,
   input  wire [IMEM_ADDR_W-1:0] fetch_addr_i,
   output instr_t                instr_o
);

   localparam int DEPTH = 2 ** IMEM_ADDR_W;

   instr_t mem [DEPTH];

   // Program load port
   always_ff @(posedge clk_i) begin
      if (load_we_i) begin
         mem[load_addr_i] <= load_data_i;
      end
   end

   // Word is kept until the next fetch so decode sees a stable instruction
   always_ff @(posedge clk_i) begin
      if (fetch_en_i) begin
         instr_o <= mem[fetch_addr_i];
      end
   end

   // Loading a program while the core is fetching would corrupt it
   a_no_load_during_fetch: assert property (@(posedge clk_i)
      !(load_we_i && fetch_en_i))
      else $error("instr_memory: program load while fetching");

endmodule

`default_nettype wire

//--- src/instruction_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module instruction_decoder
   import cpu_pkg::*;
(
   input  wire instr_t   instr_i,
   output instr_type_e   instr_type_o,
   output reg_idx_t      rd_o,
   output reg_idx_t      rs0_o,
   output reg_idx_t      rs1_o,
   output word_t         imm_o,
   output alu_op_e       alu_op_o
);

   logic [4:0] type_bits;

   assign type_bits = instr_i[TYPE_MSB:TYPE_LSB];

   // Unknown type codes fall back to a no-op
   always_comb begin
      case (type_bits)
         INSTR_ALU_OP,
         INSTR_LOAD_IMMEDIATE,
         INSTR_LOAD,
         INSTR_STORE,
         INSTR_JUMP,
         INSTR_HALT: begin
            instr_type_o = instr_type_e'(type_bits);
         end
         default: begin
            instr_type_o = INSTR_NOP;
         end
      endcase
   end

   assign rd_o  = instr_i[RD_MSB:RD_LSB];
   assign rs0_o = instr_i[RS0_MSB:RS0_LSB];
   assign rs1_o = instr_i[RS1_MSB:RS1_LSB];

   assign imm_o = word_t'(instr_i[IMM_MSB:IMM_LSB]);   // Zero extension

   // Codes above SLT are handled as ADD inside the ALU
   assign alu_op_o = alu_op_e'(instr_i[ALU_OP_MSB:ALU_OP_LSB]);

endmodule

`default_nettype wire

//--- src/stage_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module stage_sequencer
   import cpu_pkg::*;
#(
   parameter int IMEM_ADDR_W = 6
) (
   input  wire                    clk_i,
   input  wire                    rst_n_i,
   input  wire                    run_i,
   input  wire instr_type_e       instr_type_i,
   input  wire word_t             read_data_0_i,
   input  wire word_t             read_data_1_i,
   output stage_e                 stage_o,
   output logic [IMEM_ADDR_W-1:0] pc_o,
   output logic                   fetch_en_o,
   output word_t                  mem_addr_o,
   output logic                   mem_we_o,
   output logic                   mem_re_o,
   output logic                   halted_o
);

   stage_e                 stage_q;
   stage_e                 stage_d;
   logic [IMEM_ADDR_W-1:0] pc_q;
   logic                   last_stage;
   logic                   jump_taken;

   assign jump_taken = (instr_type_i == INSTR_JUMP) && (read_data_0_i != '0);

   // Instruction retires at the end of this cycle
   assign last_stage = (stage_q == STAGE_REGISTER_UPDATE) ||
                       (stage_q == STAGE_EXECUTE && instr_type_i != INSTR_ALU_OP);

   always_comb begin
      stage_d = stage_q;
      case (stage_q)
         STAGE_IDLE: begin
            if (run_i) begin
               stage_d = STAGE_FETCH;
            end
         end
         STAGE_FETCH: stage_d = STAGE_DECODE;
         STAGE_DECODE: begin
            case (instr_type_i)
               INSTR_LOAD_IMMEDIATE: stage_d = STAGE_REGISTER_UPDATE;
               INSTR_LOAD:           stage_d = STAGE_MEMORY_READ;
               INSTR_HALT:           stage_d = STAGE_HALTED;
               default:              stage_d = STAGE_EXECUTE;
            endcase
         end
         STAGE_EXECUTE: begin
            stage_d = (instr_type_i == INSTR_ALU_OP) ? STAGE_REGISTER_UPDATE : STAGE_FETCH;
         end
         STAGE_MEMORY_READ:     stage_d = STAGE_REGISTER_UPDATE;
         STAGE_REGISTER_UPDATE: stage_d = STAGE_FETCH;
         STAGE_HALTED:          stage_d = STAGE_HALTED;   // Left only by reset
         default:               stage_d = STAGE_IDLE;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         stage_q <= STAGE_IDLE;
         pc_q    <= '0;
      end else begin
         stage_q <= stage_d;
         if (last_stage) begin
            pc_q <= jump_taken ? read_data_1_i[IMEM_ADDR_W-1:0] : pc_q + 1'b1;
         end
      end
   end

   assign stage_o    = stage_q;
   assign pc_o       = pc_q;
   assign fetch_en_o = (stage_q == STAGE_FETCH);
   assign halted_o   = (stage_q == STAGE_HALTED);

   // Store address comes from rs1 and load address from rs0
   assign mem_addr_o = (instr_type_i == INSTR_STORE) ? read_data_1_i : read_data_0_i;
   assign mem_we_o   = (stage_q == STAGE_EXECUTE) && (instr_type_i == INSTR_STORE);
   assign mem_re_o   = (stage_q == STAGE_MEMORY_READ) && (instr_type_i == INSTR_LOAD);

   // The same load must still be decoded when its data arrives
   a_read_then_update: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      mem_re_o |=> (stage_q == STAGE_REGISTER_UPDATE) && (instr_type_i == INSTR_LOAD))
      else $error("stage_sequencer: load data not consumed in the next cycle");

endmodule

`default_nettype wire

//--- src/register_file_control.sv
`timescale 1ns/1ps
`default_nettype none

module register_file_control
   import cpu_pkg::*;
(
   input  wire              clk_i,
   input  wire              rst_n_i,
   input  wire stage_e      stage_i,
   input  wire instr_type_e instr_type_i,
   input  wire reg_idx_t    rd_i,
   input  wire reg_idx_t    rs0_i,
   input  wire reg_idx_t    rs1_i,
   input  wire word_t       imm_i,
   input  wire word_t       alu_result_i,
   input  wire word_t       load_mem_data_i,
   output reg_idx_t         write_address_o,
   output word_t            write_data_o,
   output logic             write_enable_o,
   output reg_idx_t         read_reg_0_o,
   output reg_idx_t         read_reg_1_o
);

   logic updates_reg_file;

   assign updates_reg_file = (instr_type_i == INSTR_ALU_OP) ||
                             (instr_type_i == INSTR_LOAD_IMMEDIATE) ||
                             (instr_type_i == INSTR_LOAD);

   assign write_enable_o = (stage_i == STAGE_REGISTER_UPDATE) && updates_reg_file;

   always_comb begin
      write_address_o = '0;
      write_data_o    = '0;
      read_reg_0_o    = '0;
      read_reg_1_o    = '0;

      case (instr_type_i)
         INSTR_LOAD_IMMEDIATE: begin
            write_address_o = rd_i;
            write_data_o    = imm_i;
         end
         INSTR_LOAD: begin
            write_address_o = rd_i;
            write_data_o    = load_mem_data_i;   // Valid in REGISTER_UPDATE
            read_reg_0_o    = rs0_i;             // Address register
         end
         INSTR_ALU_OP: begin
            write_address_o = rd_i;
            write_data_o    = alu_result_i;
            read_reg_0_o    = rs0_i;
            read_reg_1_o    = rs1_i;
         end
         INSTR_STORE: begin
            read_reg_0_o = rs0_i;   // Data
            read_reg_1_o = rs1_i;   // Address
         end
         INSTR_JUMP: begin
            read_reg_0_o = rs0_i;   // Condition
            read_reg_1_o = rs1_i;   // Target
         end
         default: begin
         end
      endcase
   end

   // Writes only happen in a single-cycle update stage
   a_write_in_update: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      write_enable_o |-> (stage_i == STAGE_REGISTER_UPDATE)
                         ##1 (stage_i != STAGE_REGISTER_UPDATE))
      else $error("register_file_control: write outside register update");

endmodule

`default_nettype wire

//--- src/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file
   import cpu_pkg::*;
(
   input  wire           clk_i,
   input  wire           rst_n_i,
   input  wire reg_idx_t read_reg_0_i,
   input  wire reg_idx_t read_reg_1_i,
   output word_t         read_data_0_o,
   output word_t         read_data_1_o,
   input  wire reg_idx_t write_address_i,
   input  wire word_t    write_data_i,
   input  wire           write_enable_i
);

   word_t regs_q [1:31];   // No storage behind register 0

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         for (int i = 1; i < 32; i++) begin
            regs_q[i] <= '0;
         end
      end else if (write_enable_i && write_address_i != '0) begin
         regs_q[write_address_i] <= write_data_i;
      end
   end

   assign read_data_0_o = (read_reg_0_i == '0) ? '0 : regs_q[read_reg_0_i];
   assign read_data_1_o = (read_reg_1_i == '0) ? '0 : regs_q[read_reg_1_i];

endmodule

`default_nettype wire

//--- src/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu
   import cpu_pkg::*;
(
   input  wire alu_op_e op_i,
   input  wire word_t   operand_0_i,
   input  wire word_t   operand_1_i,
   output word_t        result_o
);

   logic [4:0] shamt;

   assign shamt = operand_1_i[4:0];

   always_comb begin
      case (op_i)
         ALU_ADD: result_o = operand_0_i + operand_1_i;   // Wraps
         ALU_SUB: result_o = operand_0_i - operand_1_i;
         ALU_AND: result_o = operand_0_i & operand_1_i;
         ALU_OR:  result_o = operand_0_i | operand_1_i;
         ALU_XOR: result_o = operand_0_i ^ operand_1_i;
         ALU_SHL: result_o = operand_0_i << shamt;
         ALU_SHR: result_o = operand_0_i >> shamt;   // Logical shift
         ALU_SLT: begin
            result_o = ($signed(operand_0_i) < $signed(operand_1_i)) ? 32'd1 : 32'd0;
         end
         default: result_o = operand_0_i + operand_1_i;
      endcase
   end

endmodule

`default_nettype wire

//--- src/cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core
   import cpu_pkg::*;
#(
   parameter int IMEM_ADDR_W = 6
) (
   input  wire                   clk_i,
   input  wire                   rst_n_i,
   input  wire                   run_i,
   input  wire                   load_we_i,
   input  wire [IMEM_ADDR_W-1:0] load_addr_i,
   input  wire instr_t           load_data_i,
   output word_t                 mem_addr_o,
   output word_t                 mem_wdata_o,
   output logic                  mem_we_o,
   output logic                  mem_re_o,
   input  wire word_t            mem_rdata_i,
   output logic                  halted_o
);

   logic [IMEM_ADDR_W-1:0] pc;
   logic                   fetch_en;
   instr_t                 instr;
   instr_type_e            instr_type;
   reg_idx_t               rd;
   reg_idx_t               rs0;
   reg_idx_t               rs1;
   word_t                  imm;
   alu_op_e                alu_op;
   stage_e                 stage;
   reg_idx_t               read_reg_0;
   reg_idx_t               read_reg_1;
   word_t                  read_data_0;
   word_t                  read_data_1;
   reg_idx_t               write_address;
   word_t                  write_data;
   logic                   write_enable;
   word_t                  alu_result;

   instr_memory #(.IMEM_ADDR_W(IMEM_ADDR_W)) u_instr_memory (
      .clk_i, .load_we_i, .load_addr_i, .load_data_i,
      .fetch_en_i(fetch_en), .fetch_addr_i(pc), .instr_o(instr)
   );

   instruction_decoder u_instruction_decoder (
      .instr_i(instr), .instr_type_o(instr_type), .rd_o(rd), .rs0_o(rs0),
      .rs1_o(rs1), .imm_o(imm), .alu_op_o(alu_op)
   );

   stage_sequencer #(.IMEM_ADDR_W(IMEM_ADDR_W)) u_stage_sequencer (
      .clk_i, .rst_n_i, .run_i, .instr_type_i(instr_type),
      .read_data_0_i(read_data_0), .read_data_1_i(read_data_1),
      .stage_o(stage), .pc_o(pc), .fetch_en_o(fetch_en),
      .mem_addr_o, .mem_we_o, .mem_re_o, .halted_o
   );

   register_file_control u_register_file_control (
      .clk_i, .rst_n_i, .stage_i(stage), .instr_type_i(instr_type),
      .rd_i(rd), .rs0_i(rs0), .rs1_i(rs1), .imm_i(imm),
      .alu_result_i(alu_result), .load_mem_data_i(mem_rdata_i),
      .write_address_o(write_address), .write_data_o(write_data),
      .write_enable_o(write_enable), .read_reg_0_o(read_reg_0),
      .read_reg_1_o(read_reg_1)
   );

   register_file u_register_file (
      .clk_i, .rst_n_i, .read_reg_0_i(read_reg_0), .read_reg_1_i(read_reg_1),
      .read_data_0_o(read_data_0), .read_data_1_o(read_data_1),
      .write_address_i(write_address), .write_data_i(write_data),
      .write_enable_i(write_enable)
   );

   alu u_alu (
      .op_i(alu_op), .operand_0_i(read_data_0), .operand_1_i(read_data_1),
      .result_o(alu_result)
   );

   assign mem_wdata_o = read_data_0;   // Store data register

endmodule

`default_nettype wire

//--- tb/tb_cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_core
   import cpu_pkg::*;
;

   logic       clk = 1'b0;
   logic       rst_n;
   logic       run;
   logic       load_we;
   logic [5:0] load_addr;
   instr_t     load_data;
   word_t      mem_addr;
   word_t      mem_wdata;
   logic       mem_we;
   logic       mem_re;
   word_t      mem_rdata;
   logic       halted;

   word_t  dmem [256];
   instr_t prog [$];
   word_t  st_addr [$];   // Observed stores
   word_t  st_data [$];
   word_t  exp_addr [$];
   word_t  exp_data [$];
   int     seed = 62;
   int     errors = 0;
   int     errors_at_start;
   int     tests = 0;
   int     failed_tests = 0;

   cpu_core #(.IMEM_ADDR_W(6)) DUT (
      .clk_i(clk), .rst_n_i(rst_n), .run_i(run), .load_we_i(load_we),
      .load_addr_i(load_addr), .load_data_i(load_data), .mem_addr_o(mem_addr),
      .mem_wdata_o(mem_wdata), .mem_we_o(mem_we), .mem_re_o(mem_re),
      .mem_rdata_i(mem_rdata), .halted_o(halted)
   );

   always #50 clk = ~clk;

   // Data memory model with read data valid only in the cycle after mem_re
   always @(posedge clk) begin
      mem_rdata <= mem_re ? dmem[mem_addr[7:0]] : 32'hDEAD_BEEF;
      if (rst_n && mem_we) begin
         dmem[mem_addr[7:0]] <= mem_wdata;
         st_addr.push_back(mem_addr);
         st_data.push_back(mem_wdata);
      end
   end

   a_idle_quiet: assert property (@(posedge clk) disable iff (!rst_n) !run |-> !(mem_we || mem_re))
      else begin $display("Memory strobe while run_i is low"); errors++; end
   a_we_pulse: assert property (@(posedge clk) disable iff (!rst_n) mem_we |=> !mem_we)
      else begin $display("mem_we_o held longer than one cycle"); errors++; end
   a_re_pulse: assert property (@(posedge clk) disable iff (!rst_n) mem_re |=> !mem_re)
      else begin $display("mem_re_o held longer than one cycle"); errors++; end
   a_halt_sticky: assert property (@(posedge clk) disable iff (!rst_n) halted |=> halted)
      else begin $display("halted_o dropped without reset"); errors++; end
   a_halt_quiet: assert property (@(posedge clk) disable iff (!rst_n) halted |-> !(mem_we || mem_re))
      else begin $display("Memory strobe after halt"); errors++; end

   function automatic word_t fill_word(int i);
      return i * 32'h9E37_79B1 + 32'h1234_5678;
   endfunction

   function automatic instr_t encode(instr_type_e t, reg_idx_t rd, reg_idx_t rs0,
                                     logic [16:0] low);
      instr_t w;
      w = '0;
      w[TYPE_MSB:TYPE_LSB] = t;
      w[RD_MSB:RD_LSB]     = rd;
      w[RS0_MSB:RS0_LSB]   = rs0;
      w[IMM_MSB:IMM_LSB]   = low;   // rs1 and ALU op share this field
      return w;
   endfunction

   function automatic instr_t li_instr(reg_idx_t rd, word_t imm);
      return encode(INSTR_LOAD_IMMEDIATE, rd, 5'd0, imm[16:0]);
   endfunction

   function automatic instr_t alu_instr(alu_op_e op, reg_idx_t rd, reg_idx_t rs0, reg_idx_t rs1);
      return encode(INSTR_ALU_OP, rd, rs0, {rs1, 8'd0, op});
   endfunction

   function automatic instr_t ld_instr(reg_idx_t rd, reg_idx_t addr_reg);
      return encode(INSTR_LOAD, rd, addr_reg, 17'd0);
   endfunction

   function automatic instr_t st_instr(reg_idx_t data_reg, reg_idx_t addr_reg);
      return encode(INSTR_STORE, 5'd0, data_reg, {addr_reg, 12'd0});
   endfunction

   function automatic instr_t jmp_instr(reg_idx_t cond_reg, reg_idx_t target_reg);
      return encode(INSTR_JUMP, 5'd0, cond_reg, {target_reg, 12'd0});
   endfunction

   function automatic instr_t halt_instr();
      return encode(INSTR_HALT, 5'd0, 5'd0, 17'd0);
   endfunction

   // Reference results from the instruction set rules
   function automatic word_t alu_expected(int op, word_t a, word_t b);
      case (op)
         0: return a + b;
         1: return a - b;
         2: return a & b;
         3: return a | b;
         4: return a ^ b;
         5: return a << b[4:0];
         6: return a >> b[4:0];
         default: return (signed'(a) < signed'(b)) ? 32'd1 : 32'd0;
      endcase
   endfunction

   task automatic check_value(string name, word_t expected, word_t actual);
      assert (actual === expected)
         else begin
            $display("FAILED %s expected 0x%08h got 0x%08h", name, expected, actual);
            errors++;
         end
   endtask

   task automatic start_test();
      @(posedge clk);
      rst_n <= 1'b0;
      run   <= 1'b0;
      repeat (2) @(posedge clk);
      rst_n <= 1'b1;
      prog.delete();
      st_addr.delete();
      st_data.delete();
      exp_addr.delete();
      exp_data.delete();
      errors_at_start = errors;
   endtask

   task automatic end_test(string name);
      tests++;
      if (errors == errors_at_start) begin
         $display("test %-10s passed", name);
      end else begin
         failed_tests++;
         $display("test %-10s failed", name);
      end
   endtask

   task automatic expect_store(word_t a, word_t d);
      exp_addr.push_back(a);
      exp_data.push_back(d);
   endtask

   task automatic load_program();
      foreach (prog[i]) begin
         @(posedge clk);
         load_we   <= 1'b1;
         load_addr <= 6'(i);
         load_data <= prog[i];
      end
      @(posedge clk);
      load_we <= 1'b0;
   endtask

   task automatic run_program();
      int n;
      n = 0;
      load_program();
      @(posedge clk);
      run <= 1'b1;
      while (!halted && n < 1000) begin
         @(posedge clk);
         n++;
      end
      if (!halted) begin
         $display("Timeout, halted_o never went high");
         errors++;
      end
      @(posedge clk);
      run <= 1'b0;
   endtask

   task automatic check_stores();
      assert (st_addr.size() == exp_addr.size())
         else begin
            $display("Store count wrong, expected %0d stores but saw %0d",
                     exp_addr.size(), st_addr.size());
            errors++;
         end
      if (st_addr.size() == exp_addr.size()) begin
         foreach (exp_addr[i]) begin
            check_value("mem_addr_o", exp_addr[i], st_addr[i]);
            check_value("mem_wdata_o", exp_data[i], st_data[i]);
         end
      end
   endtask

   initial begin
      word_t a;
      word_t b;
      word_t x;
      int    k;
      rst_n     = 1'b0;
      run       = 1'b0;
      load_we   = 1'b0;
      load_addr = '0;
      load_data = '0;
      mem_rdata = '0;
      for (k = 0; k < 256; k++) begin
         dmem[k] = fill_word(k);
      end

      start_test();
      @(posedge clk);
      check_value("mem_we_o", 32'd0, 32'(mem_we));
      check_value("mem_re_o", 32'd0, 32'(mem_re));
      check_value("halted_o", 32'd0, 32'(halted));
      for (k = 0; k < 8; k++) begin
         @(posedge clk);
      end
      check_stores();
      end_test("reset");

      start_test();
      a = 32'h40 + (word_t'($random(seed)) & 32'hF);
      b = word_t'($random(seed)) & 32'h1FFFF;
      prog = '{li_instr(5'd1, a), li_instr(5'd2, b), st_instr(5'd2, 5'd1), halt_instr()};
      expect_store(a, b);
      run_program();
      check_stores();
      end_test("li_store");

      start_test();
      for (k = 0; k < 8; k++) begin
         a = word_t'($random(seed)) & 32'h1FFFF;
         b = word_t'($random(seed)) & 32'h1FFFF;
         prog.push_back(li_instr(5'd1, a));
         prog.push_back(li_instr(5'd2, b));
         prog.push_back(alu_instr(ALU_SUB, 5'd5, 5'd0, 5'd1));   // Negative operand
         prog.push_back(alu_instr(alu_op_e'(k), 5'd3, 5'd5, 5'd2));
         prog.push_back(li_instr(5'd4, 32'h80 + k));
         prog.push_back(st_instr(5'd3, 5'd4));
         x = alu_expected(k, 32'd0 - a, b);
         expect_store(32'h80 + k, x);
      end
      prog.push_back(alu_instr(ALU_ADD, 5'd0, 5'd1, 5'd2));
      prog.push_back(li_instr(5'd4, 32'h90));
      prog.push_back(st_instr(5'd0, 5'd4));
      prog.push_back(halt_instr());
      expect_store(32'h90, 32'd0);
      run_program();
      check_stores();
      end_test("alu");

      start_test();
      a = 32'h20 + (word_t'($random(seed)) & 32'hF);
      b = word_t'($random(seed)) & 32'h1FFFF;
      prog = '{li_instr(5'd1, a), ld_instr(5'd2, 5'd1), li_instr(5'd3, b),
               alu_instr(ALU_ADD, 5'd4, 5'd2, 5'd3), li_instr(5'd5, 32'hA0),
               st_instr(5'd4, 5'd5), halt_instr()};
      expect_store(32'hA0, fill_word(a) + b);
      run_program();
      check_stores();
      end_test("load");

      start_test();
      // Taken jump skips the store at 5 and the untaken one falls through to 7
      prog = '{li_instr(5'd1, 32'd1), li_instr(5'd2, 32'd6), li_instr(5'd6, 32'hC0),
               li_instr(5'd7, 32'hC1), jmp_instr(5'd1, 5'd2), st_instr(5'd2, 5'd6),
               jmp_instr(5'd0, 5'd2), st_instr(5'd2, 5'd7), halt_instr()};
      expect_store(32'hC1, 32'd6);
      run_program();
      check_stores();
      end_test("jump");

      start_test();
      prog = '{li_instr(5'd1, 32'h50), halt_instr(), st_instr(5'd1, 5'd1)};
      run_program();
      for (k = 0; k < 20; k++) begin
         @(posedge clk);
      end
      check_value("halted_o", 32'd1, 32'(halted));
      check_stores();
      end_test("halt");

      $display("%0d tests, %0d failed, %0d errors", tests, failed_tests, errors);
      if (errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- files.f
src/cpu_pkg.sv
src/instr_memory.sv
src/instruction_decoder.sv
src/stage_sequencer.sv
src/register_file_control.sv
src/register_file.sv
src/alu.sv
src/cpu_core.sv
tb/tb_cpu_core.sv

//--- Bender.yml
package:
  name: cpu_core

sources:
  - files:
      - src/cpu_pkg.sv
      - src/instr_memory.sv
      - src/instruction_decoder.sv
      - src/stage_sequencer.sv
      - src/register_file_control.sv
      - src/register_file.sv
      - src/alu.sv
      - src/cpu_core.sv
  - target: simulation
    files:
      - tb/tb_cpu_core.sv
